//--- Bender.yml
package:
  name: lc4_pipe

sources:
  - hdl/lc4_pkg.sv
  - hdl/lc4_ifs.sv
  - hdl/lc4_decoder.sv
  - hdl/lc4_regfile.sv
  - hdl/lc4_alu.sv
  - hdl/lc4_bypass_unit.sv
  - hdl/lc4_hazard_unit.sv
  - hdl/lc4_pipe.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_lc4_pipe.sv

//--- hdl/lc4_alu.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs_val,
    input  lc4_pkg::word_t i_rt_val,
    output lc4_pkg::word_t o_result
);
    import lc4_pkg::*;

    opcode_t op;
    word_t   imm5;
    word_t   imm6;
    word_t   imm9;

    assign op   = i_insn[15:12];
    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_result = '0;
        case (op)
            OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_val + imm5;
                end else if (i_insn[5:3] == SUB_SUB) begin
                    o_result = i_rs_val - i_rt_val;
                end else begin
                    o_result = i_rs_val + i_rt_val;
                end
            end
            OP_LOGIC: begin
                if (i_insn[5:3] == SUB_AND) begin
                    o_result = i_rs_val & i_rt_val;
                end
            end
            OP_CONST: o_result = imm9;
            // effective address for loads and stores
            OP_LDR, OP_STR: o_result = i_rs_val + imm6;
            // branch target, relative to the next pc
            OP_BR: o_result = i_pc + 16'd1 + imm9;
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/lc4_bypass_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_bypass_unit (
    lc4_fwd_if.bypass         fwd,
    input  lc4_pkg::reg_sel_t i_x_rs,
    input  lc4_pkg::reg_sel_t i_x_rt,
    input  lc4_pkg::word_t    i_x_rs_reg,
    input  lc4_pkg::word_t    i_x_rt_reg,
    input  logic              i_m_store,
    input  lc4_pkg::reg_sel_t i_m_rt,
    input  lc4_pkg::word_t    i_m_store_reg,
    input  lc4_pkg::nzp_t     i_nzp_reg,
    output lc4_pkg::word_t    o_rs_val,
    output lc4_pkg::word_t    o_rt_val,
    output lc4_pkg::word_t    o_store_data,
    output lc4_pkg::nzp_t     o_nzp_cur
);

    logic rs_mx;
    logic rs_wx;
    logic rt_mx;
    logic rt_wx;
    logic st_wm;

    assign rs_mx = fwd.m_rd_we && (fwd.m_rd == i_x_rs);
    assign rs_wx = fwd.w_rd_we && (fwd.w_rd == i_x_rs);
    assign rt_mx = fwd.m_rd_we && (fwd.m_rd == i_x_rt);
    assign rt_wx = fwd.w_rd_we && (fwd.w_rd == i_x_rt);

    // the younger producer in memory wins over writeback
    assign o_rs_val = rs_mx ? fwd.m_value :
                      rs_wx ? fwd.w_value : i_x_rs_reg;
    assign o_rt_val = rt_mx ? fwd.m_value :
                      rt_wx ? fwd.w_value : i_x_rt_reg;

    // store data picked up late from writeback
    assign st_wm        = i_m_store && fwd.w_rd_we && (fwd.w_rd == i_m_rt);
    assign o_store_data = st_wm ? fwd.w_value : i_m_store_reg;

    // condition bits about to be written at the end of memory
    assign o_nzp_cur = fwd.m_nzp_we ? fwd.m_nzp : i_nzp_reg;

endmodule

`default_nettype wire

//--- hdl/lc4_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    lc4_dec_if.dec         dec
);
    import lc4_pkg::*;

    opcode_t    op;
    logic [2:0] sub;

    assign op  = i_insn[15:12];
    assign sub = i_insn[5:3];

    always_comb begin
        dec.rs        = i_insn[8:6];
        dec.rt        = i_insn[2:0];
        dec.rd        = i_insn[11:9];
        dec.rs_re     = 1'b0;
        dec.rt_re     = 1'b0;
        dec.rd_we     = 1'b0;
        dec.nzp_we    = 1'b0;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.is_branch = 1'b0;
        case (op)
            OP_ARITH: begin
                if (i_insn[5]) begin
                    // add with 5-bit immediate
                    dec.rs_re  = 1'b1;
                    dec.rd_we  = 1'b1;
                    dec.nzp_we = 1'b1;
                end else if (sub == SUB_ADD || sub == SUB_SUB) begin
                    dec.rs_re  = 1'b1;
                    dec.rt_re  = 1'b1;
                    dec.rd_we  = 1'b1;
                    dec.nzp_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                if (!i_insn[5] && sub == SUB_AND) begin
                    dec.rs_re  = 1'b1;
                    dec.rt_re  = 1'b1;
                    dec.rd_we  = 1'b1;
                    dec.nzp_we = 1'b1;
                end
            end
            OP_CONST: begin
                dec.rd_we  = 1'b1;
                dec.nzp_we = 1'b1;
            end
            OP_LDR: begin
                dec.rs_re   = 1'b1;
                dec.rd_we   = 1'b1;
                dec.nzp_we  = 1'b1;
                dec.is_load = 1'b1;
            end
            OP_STR: begin
                // store data register sits in the rd field
                dec.rt       = i_insn[11:9];
                dec.rs_re    = 1'b1;
                dec.rt_re    = 1'b1;
                dec.is_store = 1'b1;
            end
            // an empty condition field is the bubble encoding
            OP_BR: dec.is_branch = |i_insn[11:9];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/lc4_hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_hazard_unit (
    input  logic              gwe,
    input  logic              i_rst_n,
    lc4_dec_if.hazard         dec,
    input  logic              i_x_is_load,
    input  logic              i_x_rd_we,
    input  lc4_pkg::reg_sel_t i_x_rd,
    input  logic              i_x_is_branch,
    input  lc4_pkg::nzp_t     i_x_cond,
    input  lc4_pkg::nzp_t     i_nzp_cur,
    output logic              o_load_stall,
    output logic              o_flush
);

    logic rs_hit;
    logic rt_hit;

    assign o_flush = i_x_is_branch && |(i_x_cond & i_nzp_cur);

    // store data is bypassed from memory later and never waits
    assign rs_hit = dec.rs_re && (dec.rs == i_x_rd);
    assign rt_hit = dec.rt_re && !dec.is_store && (dec.rt == i_x_rd);

    assign o_load_stall = i_x_is_load && i_x_rd_we && (rs_hit || rt_hit) && !o_flush;

    // the stall bubble in execute is never a load, so stalls come alone
    a_single_stall: assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_load_stall |=> !o_load_stall);

endmodule

`default_nettype wire

//--- hdl/lc4_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// decode result, consumed by the pipe and the hazard unit
interface lc4_dec_if;
    import lc4_pkg::*;

    reg_sel_t rs;
    reg_sel_t rt;
    reg_sel_t rd;
    logic     rs_re;
    logic     rt_re;
    logic     rd_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch;

    modport dec (output rs, rt, rd, rs_re, rt_re, rd_we, nzp_we, is_load, is_store, is_branch);
    modport pipe (input rs, rt, rd, rs_re, rt_re, rd_we, nzp_we, is_load, is_store, is_branch);
    modport hazard (input rs, rt, rs_re, rt_re, is_store);
endinterface

// forwarding sources from the memory and writeback stages
interface lc4_fwd_if;
    import lc4_pkg::*;

    logic     m_rd_we;
    reg_sel_t m_rd;
    word_t    m_value;
    logic     m_nzp_we;
    nzp_t     m_nzp;
    logic     w_rd_we;
    reg_sel_t w_rd;
    word_t    w_value;

    modport src (output m_rd_we, m_rd, m_value, m_nzp_we, m_nzp, w_rd_we, w_rd, w_value);
    modport bypass (input m_rd_we, m_rd, m_value, m_nzp_we, m_nzp, w_rd_we, w_rd, w_value);
endinterface

`default_nettype wire

//--- hdl/lc4_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_pipe (
    input  logic              gwe,
    input  logic              i_rst_n,
    output lc4_pkg::word_t    o_cur_pc,
    input  lc4_pkg::word_t    i_cur_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_wdata,
    output logic [1:0]        test_stall,
    output lc4_pkg::word_t    test_cur_pc,
    output lc4_pkg::word_t    test_cur_insn,
    output logic              test_regfile_we,
    output lc4_pkg::reg_sel_t test_regfile_wsel,
    output lc4_pkg::word_t    test_regfile_data,
    output logic              test_nzp_we,
    output lc4_pkg::nzp_t     test_nzp_new_bits,
    output logic              test_dmem_we,
    output lc4_pkg::word_t    test_dmem_addr,
    output lc4_pkg::word_t    test_dmem_data
);
    import lc4_pkg::*;

    word_t    pc;
    word_t    d_pc, d_insn;
    stall_e   d_stall;
    word_t    x_pc, x_insn, x_rs_reg, x_rt_reg;
    stall_e   x_stall;
    reg_sel_t x_rs, x_rt, x_rd;
    logic     x_rd_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
    word_t    m_pc, m_insn, m_alu, m_store_reg;
    stall_e   m_stall;
    reg_sel_t m_rt, m_rd;
    logic     m_rd_we, m_nzp_we, m_is_load, m_is_store;
    word_t    w_pc, w_insn, w_value, w_dmem_addr, w_dmem_data;
    stall_e   w_stall;
    reg_sel_t w_rd;
    nzp_t     w_nzp;
    logic     w_rd_we, w_nzp_we, w_is_store;
    nzp_t     nzp_reg, nzp_cur, m_nzp;
    word_t    rs_data, rt_data, x_rs_val, x_rt_val, alu_result, m_value, store_data;
    logic     load_stall, flush;

    lc4_dec_if dec_if ();
    lc4_fwd_if fwd_if ();

    lc4_decoder u_decoder (.i_insn(d_insn), .dec(dec_if));

    lc4_regfile u_regfile (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_rs(dec_if.rs), .i_rt(dec_if.rt),
        .o_rs_data(rs_data), .o_rt_data(rt_data),
        .i_rd(w_rd), .i_wdata(w_value), .i_we(w_rd_we)
    );

    lc4_hazard_unit u_hazard (
        .gwe(gwe), .i_rst_n(i_rst_n), .dec(dec_if),
        .i_x_is_load(x_is_load), .i_x_rd_we(x_rd_we), .i_x_rd(x_rd),
        .i_x_is_branch(x_is_branch), .i_x_cond(x_insn[11:9]), .i_nzp_cur(nzp_cur),
        .o_load_stall(load_stall), .o_flush(flush)
    );

    lc4_bypass_unit u_bypass (
        .fwd(fwd_if), .i_x_rs(x_rs), .i_x_rt(x_rt),
        .i_x_rs_reg(x_rs_reg), .i_x_rt_reg(x_rt_reg),
        .i_m_store(m_is_store), .i_m_rt(m_rt), .i_m_store_reg(m_store_reg),
        .i_nzp_reg(nzp_reg), .o_rs_val(x_rs_val), .o_rt_val(x_rt_val),
        .o_store_data(store_data), .o_nzp_cur(nzp_cur)
    );

    lc4_alu u_alu (
        .i_insn(x_insn), .i_pc(x_pc), .i_rs_val(x_rs_val), .i_rt_val(x_rt_val),
        .o_result(alu_result)
    );

    // fetch
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc <= PC_RESET;
        end else if (flush) begin
            pc <= alu_result;
        end else if (!load_stall) begin
            pc <= pc + 16'd1;
        end
    end

    // decode register holds during a load stall
    always_ff @(posedge gwe) begin
        if (!i_rst_n || flush) begin
            d_insn  <= '0;
            d_stall <= STALL_FLUSH;
        end else if (!load_stall) begin
            d_insn  <= i_cur_insn;
            d_stall <= STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!load_stall) begin
            d_pc <= pc;
        end
    end

    // a bubble enters execute on reset, flush or stall
    always_ff @(posedge gwe) begin
        if (!i_rst_n || flush || load_stall) begin
            x_insn      <= '0;
            x_stall     <= (i_rst_n && load_stall) ? STALL_LOAD : STALL_FLUSH;
            x_rd_we     <= 1'b0;
            x_nzp_we    <= 1'b0;
            x_is_load   <= 1'b0;
            x_is_store  <= 1'b0;
            x_is_branch <= 1'b0;
        end else begin
            x_insn      <= d_insn;
            x_stall     <= d_stall;
            x_rd_we     <= dec_if.rd_we;
            x_nzp_we    <= dec_if.nzp_we;
            x_is_load   <= dec_if.is_load;
            x_is_store  <= dec_if.is_store;
            x_is_branch <= dec_if.is_branch;
        end
    end

    // unread operands are zeroed to keep the datapath quiet
    always_ff @(posedge gwe) begin
        x_pc     <= d_pc;
        x_rs     <= dec_if.rs;
        x_rt     <= dec_if.rt;
        x_rd     <= dec_if.rd;
        x_rs_reg <= dec_if.rs_re ? rs_data : '0;
        x_rt_reg <= dec_if.rt_re ? rt_data : '0;
    end

    // memory
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_insn     <= '0;
            m_stall    <= STALL_FLUSH;
            m_rd_we    <= 1'b0;
            m_nzp_we   <= 1'b0;
            m_is_load  <= 1'b0;
            m_is_store <= 1'b0;
        end else begin
            m_insn     <= x_insn;
            m_stall    <= x_stall;
            m_rd_we    <= x_rd_we;
            m_nzp_we   <= x_nzp_we;
            m_is_load  <= x_is_load;
            m_is_store <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc        <= x_pc;
        m_rd        <= x_rd;
        m_rt        <= x_rt;
        m_alu       <= alu_result;
        m_store_reg <= x_rt_val;
    end

    assign m_value      = m_is_load ? i_dmem_rdata : m_alu;
    assign m_nzp        = m_value[15] ? 3'b100 : (m_value == '0) ? 3'b010 : 3'b001;
    assign o_dmem_addr  = (m_is_load || m_is_store) ? m_alu : '0;
    assign o_dmem_we    = m_is_store;
    assign o_dmem_wdata = store_data;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_reg <= '0;
        end else if (m_nzp_we) begin
            nzp_reg <= m_nzp;
        end
    end

    // writeback
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            w_insn     <= '0;
            w_stall    <= STALL_FLUSH;
            w_rd_we    <= 1'b0;
            w_nzp_we   <= 1'b0;
            w_is_store <= 1'b0;
        end else begin
            w_insn     <= m_insn;
            w_stall    <= m_stall;
            w_rd_we    <= m_rd_we;
            w_nzp_we   <= m_nzp_we;
            w_is_store <= m_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        w_pc        <= m_pc;
        w_rd        <= m_rd;
        w_value     <= m_value;
        w_nzp       <= m_nzp;
        w_dmem_addr <= o_dmem_addr;
        w_dmem_data <= m_is_load ? i_dmem_rdata : (m_is_store ? store_data : '0);
    end

    assign fwd_if.m_rd_we  = m_rd_we;
    assign fwd_if.m_rd     = m_rd;
    assign fwd_if.m_value  = m_value;
    assign fwd_if.m_nzp_we = m_nzp_we;
    assign fwd_if.m_nzp    = m_nzp;
    assign fwd_if.w_rd_we  = w_rd_we;
    assign fwd_if.w_rd     = w_rd;
    assign fwd_if.w_value  = w_value;

    assign o_cur_pc          = pc;
    assign test_stall        = w_stall;
    assign test_cur_pc       = w_pc;
    assign test_cur_insn     = w_insn;
    assign test_regfile_we   = w_rd_we;
    assign test_regfile_wsel = w_rd;
    assign test_regfile_data = w_value;
    assign test_nzp_we       = w_nzp_we;
    assign test_nzp_new_bits = w_nzp;
    assign test_dmem_we      = w_is_store;
    assign test_dmem_addr    = w_dmem_addr;
    assign test_dmem_data    = w_dmem_data;

    // the store flag carried from decode must match the encoding in memory
    a_store_only: assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_dmem_we |-> (m_insn[15:12] == OP_STR));

endmodule

`default_nettype wire

//--- hdl/lc4_pkg.sv
`default_nettype none

package lc4_pkg;

    // data, address and instruction words share one width
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;

    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0]  nzp_t;
    typedef logic [3:0]  opcode_t;

    // trace stall codes, code 1 is not produced by a single pipe
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_e;

    localparam word_t PC_RESET = 16'h8200;

    localparam opcode_t OP_BR    = 4'b0000;
    localparam opcode_t OP_ARITH = 4'b0001;
    localparam opcode_t OP_LOGIC = 4'b0101;
    localparam opcode_t OP_LDR   = 4'b0110;
    localparam opcode_t OP_STR   = 4'b0111;
    localparam opcode_t OP_CONST = 4'b1001;

    // sub-op field insn[5:3], arith and logic groups
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;

    localparam int NUM_REGS = 8;

endpackage

`default_nettype wire

//--- hdl/lc4_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::reg_sel_t i_rs,
    input  lc4_pkg::reg_sel_t i_rt,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_sel_t i_rd,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write before read, decode sees the writeback value this cycle
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

    // a committed write must carry a known value
    a_wdata_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_we |-> !$isunknown(i_wdata));

endmodule

`default_nettype wire

//--- lc4_pipe.f
hdl/lc4_pkg.sv
hdl/lc4_ifs.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile.sv
hdl/lc4_alu.sv
hdl/lc4_bypass_unit.sv
hdl/lc4_hazard_unit.sv
hdl/lc4_pipe.sv
test/tb_clock.sv
test/tb_lc4_pipe.sv

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic gwe,
    output logic o_rst_n
);

    initial begin
        gwe = 1'b0;
        forever #(PERIOD / 2) gwe = ~gwe;
    end

    // reset released a little after a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge gwe);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_lc4_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lc4_pipe;
    import lc4_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_COMMITS = 2000;
    localparam int MEM_WORDS   = 256;

    logic       gwe;
    logic       rst_n;
    word_t      cur_pc;
    word_t      cur_insn;
    word_t      dmem_addr;
    word_t      dmem_rdata;
    word_t      dmem_wdata;
    logic       dmem_we;
    logic [1:0] test_stall;
    word_t      test_cur_pc;
    word_t      test_cur_insn;
    logic       test_regfile_we;
    reg_sel_t   test_regfile_wsel;
    word_t      test_regfile_data;
    logic       test_nzp_we;
    nzp_t       test_nzp_new_bits;
    logic       test_dmem_we;
    word_t      test_dmem_addr;
    word_t      test_dmem_data;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    // reference model state
    word_t ref_regs [NUM_REGS];
    word_t ref_dmem [MEM_WORDS];
    nzp_t  ref_nzp;
    word_t ref_pc;

    integer     seed;
    int         commits;
    int         error_count;
    int         pending_bubbles;
    logic [1:0] pending_code;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (.gwe(gwe), .o_rst_n(rst_n));

    lc4_pipe uut (
        .gwe(gwe), .i_rst_n(rst_n),
        .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .i_dmem_rdata(dmem_rdata),
        .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
        .test_stall(test_stall), .test_cur_pc(test_cur_pc), .test_cur_insn(test_cur_insn),
        .test_regfile_we(test_regfile_we), .test_regfile_wsel(test_regfile_wsel),
        .test_regfile_data(test_regfile_data), .test_nzp_we(test_nzp_we),
        .test_nzp_new_bits(test_nzp_new_bits), .test_dmem_we(test_dmem_we),
        .test_dmem_addr(test_dmem_addr), .test_dmem_data(test_dmem_data)
    );

    // both memories answer in the same cycle
    assign cur_insn   = $isunknown(cur_pc) ? 16'h0000 : imem[cur_pc[7:0]];
    assign dmem_rdata = $isunknown(dmem_addr) ? 16'h0000 : dmem[dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    function automatic word_t sign_extend(input word_t value, input int width);
        word_t upper;
        upper = 16'hffff << width;
        if (value[width - 1]) begin
            return value | upper;
        end
        return value & ~upper;
    endfunction

    function automatic nzp_t nzp_of(input word_t value);
        if (value[15]) begin
            return 3'b100;
        end
        if (value == 16'd0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // true when insn needs register r in execute but not as store data
    function automatic logic reads_reg(input word_t insn, input reg_sel_t r);
        case (insn[15:12])
            OP_ARITH: return (insn[8:6] == r) || (!insn[5] && insn[2:0] == r);
            OP_LOGIC: return (insn[8:6] == r) || (insn[2:0] == r);
            OP_LDR, OP_STR: return insn[8:6] == r;
            default: return 1'b0;
        endcase
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s is %h, expected %h (commit %0d, time %0t)",
                     name, got, exp, commits, $time);
            abort_run();
        end
    endtask

    task automatic fill_program();
        logic [31:0] r;
        reg_sel_t    last_rd;
        reg_sel_t    rd;
        reg_sel_t    rs;
        reg_sel_t    rt;
        last_rd = 3'd0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r  = $random(seed);
            rd = r[10:8];
            // sources often name the last written register
            rs = r[13] ? last_rd : r[16:14];
            rt = r[17] ? last_rd : r[20:18];
            case (r[3:0])
                4'd0, 4'd1: imem[i] = {OP_ARITH, rd, rs, SUB_ADD, rt};
                4'd2:       imem[i] = {OP_ARITH, rd, rs, SUB_SUB, rt};
                4'd3:       imem[i] = {OP_LOGIC, rd, rs, SUB_AND, rt};
                4'd4, 4'd5: imem[i] = {OP_ARITH, rd, rs, 1'b1, r[25:21]};
                4'd6, 4'd7: imem[i] = {OP_CONST, rd, r[29:21]};
                4'd8, 4'd9, 4'd10, 4'd11: imem[i] = {OP_LDR, rd, rs, r[26:21]};
                4'd12, 4'd13: imem[i] = {OP_STR, rt, rs, r[26:21]};
                default:    imem[i] = {OP_BR, r[22:20], r[31:23]};
            endcase
            if (r[3:0] < 4'd12) begin
                last_rd = rd;
            end
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i]     = {i[7:0] ^ 8'h5a, ~i[7:0]};
            ref_dmem[i] = {i[7:0] ^ 8'h5a, ~i[7:0]};
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = 16'h0000;
        end
        ref_nzp = 3'b000;
        ref_pc  = PC_RESET;
    endtask

    // data memory written by the core against the model copy
    task automatic compare_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], ref_dmem[i]);
        end
    endtask

    task automatic check_bubble();
        check_value("test_stall", test_stall, pending_code);
        check_value("test_regfile_we", test_regfile_we, 1'b0);
        check_value("test_nzp_we", test_nzp_we, 1'b0);
        check_value("test_dmem_we", test_dmem_we, 1'b0);
        pending_bubbles--;
    endtask

    // one instruction of the ISA model against the trace ports
    task automatic execute_reference();
        word_t    insn;
        word_t    a;
        word_t    b;
        word_t    value;
        word_t    exp_addr;
        word_t    exp_data;
        word_t    next_pc;
        reg_sel_t rd;
        logic     we;
        logic     st_we;
        insn     = imem[ref_pc[7:0]];
        rd       = insn[11:9];
        a        = ref_regs[insn[8:6]];
        b        = ref_regs[insn[2:0]];
        we       = 1'b0;
        st_we    = 1'b0;
        value    = 16'h0000;
        exp_addr = 16'h0000;
        exp_data = 16'h0000;
        next_pc  = ref_pc + 16'd1;
        pending_bubbles = 0;
        pending_code    = STALL_NONE;
        case (insn[15:12])
            OP_ARITH: begin
                we = 1'b1;
                if (insn[5]) begin
                    value = a + sign_extend(insn, 5);
                end else if (insn[5:3] == SUB_SUB) begin
                    value = a - b;
                end else begin
                    value = a + b;
                end
            end
            OP_LOGIC: begin
                we    = 1'b1;
                value = a & b;
            end
            OP_CONST: begin
                we    = 1'b1;
                value = sign_extend(insn, 9);
            end
            OP_LDR: begin
                we       = 1'b1;
                exp_addr = a + sign_extend(insn, 6);
                value    = ref_dmem[exp_addr[7:0]];
                exp_data = value;
                // the next instruction waits one cycle if it uses the loaded value
                if (reads_reg(imem[next_pc[7:0]], rd)) begin
                    pending_bubbles = 1;
                    pending_code    = STALL_LOAD;
                end
            end
            OP_STR: begin
                st_we    = 1'b1;
                exp_addr = a + sign_extend(insn, 6);
                exp_data = ref_regs[rd];
                ref_dmem[exp_addr[7:0]] = exp_data;
            end
            default: begin
                if (|(insn[11:9] & ref_nzp)) begin
                    next_pc         = ref_pc + 16'd1 + sign_extend(insn, 9);
                    pending_bubbles = 2;
                    pending_code    = STALL_FLUSH;
                end
            end
        endcase
        check_value("test_cur_pc", test_cur_pc, ref_pc);
        check_value("test_cur_insn", test_cur_insn, insn);
        check_value("test_regfile_we", test_regfile_we, we);
        check_value("test_nzp_we", test_nzp_we, we);
        check_value("test_dmem_we", test_dmem_we, st_we);
        check_value("test_dmem_addr", test_dmem_addr, exp_addr);
        check_value("test_dmem_data", test_dmem_data, exp_data);
        if (st_we) begin
            // the store was written into memory at the end of its memory stage
            check_value("dmem", dmem[exp_addr[7:0]], exp_data);
        end
        if (we) begin
            check_value("test_regfile_wsel", test_regfile_wsel, rd);
            check_value("test_regfile_data", test_regfile_data, value);
            check_value("test_nzp_new_bits", test_nzp_new_bits, nzp_of(value));
            ref_regs[rd] = value;
            ref_nzp      = nzp_of(value);
        end
        ref_pc = next_pc;
        commits++;
    endtask

    initial begin
        seed        = 84952;
        commits     = 0;
        error_count = 0;
        fill_program();
        reset_model();
        wait (rst_n === 1'b1);
        // four flush cycles before the first instruction reaches writeback
        pending_bubbles = 4;
        pending_code    = STALL_FLUSH;
        while (commits < NUM_COMMITS) begin
            @(negedge gwe);
            if (pending_bubbles > 0) begin
                check_bubble();
            end else begin
                check_value("test_stall", test_stall, STALL_NONE);
                execute_reference();
            end
        end
        compare_memory();
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

    // each commit costs at most three cycles
    initial begin
        #(NUM_COMMITS * 3 * CLK_PERIOD + 1000);
        $display("timeout: only %0d of %0d instructions committed", commits, NUM_COMMITS);
        abort_run();
    end

endmodule

`default_nettype wire
